/* common/axil_pkg.sv */
// AXI-Lite bus widths and response codes.
// Shared by the cut stages, the register slave and the testbench.
package axil_pkg;

  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned STRB_W = DATA_W / 8;
  localparam int unsigned RESP_W = 2;

  localparam logic [RESP_W-1:0] RESP_OKAY   = 2'b00;
  localparam logic [RESP_W-1:0] RESP_SLVERR = 2'b10;

endpackage

/* common/regs_pkg.sv */
// Register map of the AXI-Lite register slave.
// The address union splits a bus address into word index and byte offset.
package regs_pkg;

  // Scratch registers sit at word indices 0 to 3
  localparam int unsigned N_SCRATCH = 4;
  localparam int unsigned IDX_W     = 3;

  // Read-only transaction counters
  localparam logic [IDX_W-1:0] IDX_WRCNT = 3'd4;
  localparam logic [IDX_W-1:0] IDX_RDCNT = 3'd5;

  typedef struct packed {
    logic [26:0]      upper;
    logic [IDX_W-1:0] idx;
    logic [1:0]       offset;
  } reg_addr_s;

  // One address word, read raw or as decoded fields
  typedef union packed {
    logic [31:0] raw;
    reg_addr_s   f;
  } reg_addr_u;

endpackage

/* axil_cut/axil_spill_reg.sv */
// Two-entry register slice for one valid/ready channel.
// Registers both valid and ready while keeping one transfer per cycle.
`timescale 1ns/1ps

module axil_spill_reg #(
  parameter int unsigned WIDTH = 32
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             valid_i,
  output logic             ready_o,
  input  logic [WIDTH-1:0] data_i,
  output logic             valid_o,
  input  logic             ready_i,
  output logic [WIDTH-1:0] data_o
);

  // Entry A drives the output, entry B catches an item under back-pressure
  logic             a_full_q, b_full_q, ready_q;
  logic             a_full_d, b_full_d;
  logic [WIDTH-1:0] a_data_q, b_data_q;
  logic             push, pop;

  assign push = valid_i & ready_q;
  assign pop  = a_full_q & ready_i;

  always_comb begin
    a_full_d = a_full_q;
    b_full_d = b_full_q;
    if (pop && !push) begin
      if (b_full_q) b_full_d = 1'b0;
      else          a_full_d = 1'b0;
    end else if (push && !pop) begin
      if (a_full_q) b_full_d = 1'b1;
      else          a_full_d = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
      ready_q  <= 1'b0;
    end else begin
      a_full_q <= a_full_d;
      b_full_q <= b_full_d;
      ready_q  <= ~b_full_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if ((push && (!a_full_q || pop)) || (pop && b_full_q))
      a_data_q <= b_full_q ? b_data_q : data_i;
    if (push && a_full_q && !pop)
      b_data_q <= data_i;
  end

  assign valid_o = a_full_q;
  assign ready_o = ready_q;
  assign data_o  = a_data_q;

  a_hold_data: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_o && !ready_i |=> $stable(data_o));

endmodule

/* axil_cut/axil_cut.sv */
// One AXI-Lite pipeline stage.
// Requests and responses each pass through their own spill register.
`timescale 1ns/1ps

module axil_cut (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  // Slave side
  input  logic                           slv_awvalid_i,
  output logic                           slv_awready_o,
  input  logic [axil_pkg::ADDR_W-1:0]    slv_awaddr_i,
  input  logic                           slv_wvalid_i,
  output logic                           slv_wready_o,
  input  logic [axil_pkg::DATA_W-1:0]    slv_wdata_i,
  input  logic [axil_pkg::STRB_W-1:0]    slv_wstrb_i,
  output logic                           slv_bvalid_o,
  input  logic                           slv_bready_i,
  output logic [axil_pkg::RESP_W-1:0]    slv_bresp_o,
  input  logic                           slv_arvalid_i,
  output logic                           slv_arready_o,
  input  logic [axil_pkg::ADDR_W-1:0]    slv_araddr_i,
  output logic                           slv_rvalid_o,
  input  logic                           slv_rready_i,
  output logic [axil_pkg::DATA_W-1:0]    slv_rdata_o,
  output logic [axil_pkg::RESP_W-1:0]    slv_rresp_o,
  // Master side
  output logic                           mst_awvalid_o,
  input  logic                           mst_awready_i,
  output logic [axil_pkg::ADDR_W-1:0]    mst_awaddr_o,
  output logic                           mst_wvalid_o,
  input  logic                           mst_wready_i,
  output logic [axil_pkg::DATA_W-1:0]    mst_wdata_o,
  output logic [axil_pkg::STRB_W-1:0]    mst_wstrb_o,
  input  logic                           mst_bvalid_i,
  output logic                           mst_bready_o,
  input  logic [axil_pkg::RESP_W-1:0]    mst_bresp_i,
  output logic                           mst_arvalid_o,
  input  logic                           mst_arready_i,
  output logic [axil_pkg::ADDR_W-1:0]    mst_araddr_o,
  input  logic                           mst_rvalid_i,
  output logic                           mst_rready_o,
  input  logic [axil_pkg::DATA_W-1:0]    mst_rdata_i,
  input  logic [axil_pkg::RESP_W-1:0]    mst_rresp_i
);

  localparam int unsigned W_W = axil_pkg::DATA_W + axil_pkg::STRB_W;
  localparam int unsigned R_W = axil_pkg::DATA_W + axil_pkg::RESP_W;

  axil_spill_reg #(.WIDTH(axil_pkg::ADDR_W)) i_aw (
    .clk_i, .rst_n_i,
    .valid_i(slv_awvalid_i), .ready_o(slv_awready_o), .data_i(slv_awaddr_i),
    .valid_o(mst_awvalid_o), .ready_i(mst_awready_i), .data_o(mst_awaddr_o)
  );

  // Data and strobe travel as one word
  axil_spill_reg #(.WIDTH(W_W)) i_w (
    .clk_i, .rst_n_i,
    .valid_i(slv_wvalid_i), .ready_o(slv_wready_o), .data_i({slv_wdata_i, slv_wstrb_i}),
    .valid_o(mst_wvalid_o), .ready_i(mst_wready_i), .data_o({mst_wdata_o, mst_wstrb_o})
  );

  axil_spill_reg #(.WIDTH(axil_pkg::RESP_W)) i_b (
    .clk_i, .rst_n_i,
    .valid_i(mst_bvalid_i), .ready_o(mst_bready_o), .data_i(mst_bresp_i),
    .valid_o(slv_bvalid_o), .ready_i(slv_bready_i), .data_o(slv_bresp_o)
  );

  axil_spill_reg #(.WIDTH(axil_pkg::ADDR_W)) i_ar (
    .clk_i, .rst_n_i,
    .valid_i(slv_arvalid_i), .ready_o(slv_arready_o), .data_i(slv_araddr_i),
    .valid_o(mst_arvalid_o), .ready_i(mst_arready_i), .data_o(mst_araddr_o)
  );

  axil_spill_reg #(.WIDTH(R_W)) i_r (
    .clk_i, .rst_n_i,
    .valid_i(mst_rvalid_i), .ready_o(mst_rready_o), .data_i({mst_rdata_i, mst_rresp_i}),
    .valid_o(slv_rvalid_o), .ready_i(slv_rready_i), .data_o({slv_rdata_o, slv_rresp_o})
  );

endmodule

/* axil_cut/axil_multicut.sv */
// Chain of AXI-Lite cut stages for long buses.
// Each stage adds one cycle on requests and one on responses.
`timescale 1ns/1ps

module axil_multicut #(
  parameter int unsigned NoCuts = 1
) (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic                           slv_awvalid_i,
  output logic                           slv_awready_o,
  input  logic [axil_pkg::ADDR_W-1:0]    slv_awaddr_i,
  input  logic                           slv_wvalid_i,
  output logic                           slv_wready_o,
  input  logic [axil_pkg::DATA_W-1:0]    slv_wdata_i,
  input  logic [axil_pkg::STRB_W-1:0]    slv_wstrb_i,
  output logic                           slv_bvalid_o,
  input  logic                           slv_bready_i,
  output logic [axil_pkg::RESP_W-1:0]    slv_bresp_o,
  input  logic                           slv_arvalid_i,
  output logic                           slv_arready_o,
  input  logic [axil_pkg::ADDR_W-1:0]    slv_araddr_i,
  output logic                           slv_rvalid_o,
  input  logic                           slv_rready_i,
  output logic [axil_pkg::DATA_W-1:0]    slv_rdata_o,
  output logic [axil_pkg::RESP_W-1:0]    slv_rresp_o,
  output logic                           mst_awvalid_o,
  input  logic                           mst_awready_i,
  output logic [axil_pkg::ADDR_W-1:0]    mst_awaddr_o,
  output logic                           mst_wvalid_o,
  input  logic                           mst_wready_i,
  output logic [axil_pkg::DATA_W-1:0]    mst_wdata_o,
  output logic [axil_pkg::STRB_W-1:0]    mst_wstrb_o,
  input  logic                           mst_bvalid_i,
  output logic                           mst_bready_o,
  input  logic [axil_pkg::RESP_W-1:0]    mst_bresp_i,
  output logic                           mst_arvalid_o,
  input  logic                           mst_arready_i,
  output logic [axil_pkg::ADDR_W-1:0]    mst_araddr_o,
  input  logic                           mst_rvalid_i,
  output logic                           mst_rready_o,
  input  logic [axil_pkg::DATA_W-1:0]    mst_rdata_i,
  input  logic [axil_pkg::RESP_W-1:0]    mst_rresp_i
);

  // Index 0 is the slave side, index NoCuts the master side
  logic [NoCuts:0]                        awvalid, awready, wvalid, wready, bvalid, bready;
  logic [NoCuts:0]                        arvalid, arready, rvalid, rready;
  logic [NoCuts:0][axil_pkg::ADDR_W-1:0]  awaddr, araddr;
  logic [NoCuts:0][axil_pkg::DATA_W-1:0]  wdata, rdata;
  logic [NoCuts:0][axil_pkg::STRB_W-1:0]  wstrb;
  logic [NoCuts:0][axil_pkg::RESP_W-1:0]  bresp, rresp;

  assign awvalid[0]     = slv_awvalid_i;
  assign awaddr[0]      = slv_awaddr_i;
  assign slv_awready_o  = awready[0];
  assign wvalid[0]      = slv_wvalid_i;
  assign wdata[0]       = slv_wdata_i;
  assign wstrb[0]       = slv_wstrb_i;
  assign slv_wready_o   = wready[0];
  assign slv_bvalid_o   = bvalid[0];
  assign slv_bresp_o    = bresp[0];
  assign bready[0]      = slv_bready_i;
  assign arvalid[0]     = slv_arvalid_i;
  assign araddr[0]      = slv_araddr_i;
  assign slv_arready_o  = arready[0];
  assign slv_rvalid_o   = rvalid[0];
  assign slv_rdata_o    = rdata[0];
  assign slv_rresp_o    = rresp[0];
  assign rready[0]      = slv_rready_i;

  // With NoCuts of zero the loop is empty and both ends share index 0
  for (genvar i = 0; i < NoCuts; i++) begin : gen_cuts
    axil_cut i_cut (
      .clk_i, .rst_n_i,
      .slv_awvalid_i(awvalid[i]), .slv_awready_o(awready[i]), .slv_awaddr_i(awaddr[i]),
      .slv_wvalid_i(wvalid[i]), .slv_wready_o(wready[i]),
      .slv_wdata_i(wdata[i]), .slv_wstrb_i(wstrb[i]),
      .slv_bvalid_o(bvalid[i]), .slv_bready_i(bready[i]), .slv_bresp_o(bresp[i]),
      .slv_arvalid_i(arvalid[i]), .slv_arready_o(arready[i]), .slv_araddr_i(araddr[i]),
      .slv_rvalid_o(rvalid[i]), .slv_rready_i(rready[i]),
      .slv_rdata_o(rdata[i]), .slv_rresp_o(rresp[i]),
      .mst_awvalid_o(awvalid[i+1]), .mst_awready_i(awready[i+1]), .mst_awaddr_o(awaddr[i+1]),
      .mst_wvalid_o(wvalid[i+1]), .mst_wready_i(wready[i+1]),
      .mst_wdata_o(wdata[i+1]), .mst_wstrb_o(wstrb[i+1]),
      .mst_bvalid_i(bvalid[i+1]), .mst_bready_o(bready[i+1]), .mst_bresp_i(bresp[i+1]),
      .mst_arvalid_o(arvalid[i+1]), .mst_arready_i(arready[i+1]), .mst_araddr_o(araddr[i+1]),
      .mst_rvalid_i(rvalid[i+1]), .mst_rready_o(rready[i+1]),
      .mst_rdata_i(rdata[i+1]), .mst_rresp_i(rresp[i+1])
    );
  end

  assign mst_awvalid_o   = awvalid[NoCuts];
  assign mst_awaddr_o    = awaddr[NoCuts];
  assign awready[NoCuts] = mst_awready_i;
  assign mst_wvalid_o    = wvalid[NoCuts];
  assign mst_wdata_o     = wdata[NoCuts];
  assign mst_wstrb_o     = wstrb[NoCuts];
  assign wready[NoCuts]  = mst_wready_i;
  assign bvalid[NoCuts]  = mst_bvalid_i;
  assign bresp[NoCuts]   = mst_bresp_i;
  assign mst_bready_o    = bready[NoCuts];
  assign mst_arvalid_o   = arvalid[NoCuts];
  assign mst_araddr_o    = araddr[NoCuts];
  assign arready[NoCuts] = mst_arready_i;
  assign rvalid[NoCuts]  = mst_rvalid_i;
  assign rdata[NoCuts]   = mst_rdata_i;
  assign rresp[NoCuts]   = mst_rresp_i;
  assign mst_rready_o    = rready[NoCuts];

endmodule

/* hw/axil_reg_ctrl.sv */
// AXI-Lite slave controller for the register block.
// Takes AW with W, or AR, and answers with one B or R beat.
`timescale 1ns/1ps

module axil_reg_ctrl (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic                           awvalid_i,
  output logic                           awready_o,
  input  logic [axil_pkg::ADDR_W-1:0]    awaddr_i,
  input  logic                           wvalid_i,
  output logic                           wready_o,
  input  logic [axil_pkg::DATA_W-1:0]    wdata_i,
  input  logic [axil_pkg::STRB_W-1:0]    wstrb_i,
  output logic                           bvalid_o,
  input  logic                           bready_i,
  output logic [axil_pkg::RESP_W-1:0]    bresp_o,
  input  logic                           arvalid_i,
  output logic                           arready_o,
  input  logic [axil_pkg::ADDR_W-1:0]    araddr_i,
  output logic                           rvalid_o,
  input  logic                           rready_i,
  output logic [axil_pkg::DATA_W-1:0]    rdata_o,
  output logic [axil_pkg::RESP_W-1:0]    rresp_o,
  output logic                           wr_en_o,
  output logic [regs_pkg::IDX_W-1:0]     wr_idx_o,
  output logic [axil_pkg::DATA_W-1:0]    wr_data_o,
  output logic [axil_pkg::STRB_W-1:0]    wr_strb_o,
  output logic [regs_pkg::IDX_W-1:0]     rd_idx_o,
  input  logic [axil_pkg::DATA_W-1:0]    rd_data_i,
  output logic                           wr_done_o,
  output logic                           rd_done_o
);

  typedef enum logic [1:0] {IDLE, WRESP, RRESP} state_e;

  state_e                         state_q;
  regs_pkg::reg_addr_u            waddr, raddr;
  logic                           wr_acc, rd_acc, wr_ok, rd_ok;
  logic [axil_pkg::RESP_W-1:0]    bresp_q, rresp_q;
  logic [axil_pkg::DATA_W-1:0]    rdata_q;

  assign waddr.raw = awaddr_i;
  assign raddr.raw = araddr_i;

  // Only scratch registers take writes, counters are read-only
  assign wr_ok = (waddr.f.upper == '0) && (waddr.f.idx < regs_pkg::N_SCRATCH);
  assign rd_ok = (raddr.f.upper == '0) && (raddr.f.idx <= regs_pkg::IDX_RDCNT);

  // Writes win when both kinds are waiting
  assign wr_acc    = (state_q == IDLE) && awvalid_i && wvalid_i;
  assign rd_acc    = (state_q == IDLE) && arvalid_i && !(awvalid_i && wvalid_i);
  assign awready_o = wr_acc;
  assign wready_o  = wr_acc;
  assign arready_o = rd_acc;

  assign wr_en_o   = wr_acc && wr_ok;
  assign wr_idx_o  = waddr.f.idx;
  assign wr_data_o = wdata_i;
  assign wr_strb_o = wstrb_i;
  assign rd_idx_o  = raddr.f.idx;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
    end else begin
      case (state_q)
        IDLE: begin
          if (wr_acc)      state_q <= WRESP;
          else if (rd_acc) state_q <= RRESP;
        end
        WRESP:   if (bready_i) state_q <= IDLE;
        RRESP:   if (rready_i) state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  // Response payload is captured at accept and held until the handshake
  always_ff @(posedge clk_i) begin
    if (wr_acc)
      bresp_q <= wr_ok ? axil_pkg::RESP_OKAY : axil_pkg::RESP_SLVERR;
    if (rd_acc) begin
      rresp_q <= rd_ok ? axil_pkg::RESP_OKAY : axil_pkg::RESP_SLVERR;
      rdata_q <= rd_ok ? rd_data_i : '0;
    end
  end

  assign bvalid_o = (state_q == WRESP);
  assign rvalid_o = (state_q == RRESP);
  assign bresp_o  = bresp_q;
  assign rresp_o  = rresp_q;
  assign rdata_o  = rdata_q;

  assign wr_done_o = bvalid_o && bready_i && (bresp_q == axil_pkg::RESP_OKAY);
  assign rd_done_o = rvalid_o && rready_i && (rresp_q == axil_pkg::RESP_OKAY);

  a_one_resp: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(bvalid_o && rvalid_o));

  a_wr_en_hs: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wr_en_o |-> awvalid_i && awready_o && wvalid_i && wready_o);

endmodule

/* hw/axil_reg_file.sv */
// Scratch register storage with byte-strobe writes.
// The read mux also exposes the two transaction counters.
`timescale 1ns/1ps

module axil_reg_file (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic                           wr_en_i,
  input  logic [regs_pkg::IDX_W-1:0]     wr_idx_i,
  input  logic [axil_pkg::DATA_W-1:0]    wr_data_i,
  input  logic [axil_pkg::STRB_W-1:0]    wr_strb_i,
  input  logic [regs_pkg::IDX_W-1:0]     rd_idx_i,
  output logic [axil_pkg::DATA_W-1:0]    rd_data_o,
  input  logic [axil_pkg::DATA_W-1:0]    wr_cnt_i,
  input  logic [axil_pkg::DATA_W-1:0]    rd_cnt_i
);

  localparam int unsigned SEL_W = $clog2(regs_pkg::N_SCRATCH);

  logic [regs_pkg::N_SCRATCH-1:0][axil_pkg::DATA_W-1:0] scratch_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      scratch_q <= '0;
    end else if (wr_en_i) begin
      for (int b = 0; b < axil_pkg::STRB_W; b++) begin
        if (wr_strb_i[b])
          scratch_q[wr_idx_i[SEL_W-1:0]][b*8 +: 8] <= wr_data_i[b*8 +: 8];
      end
    end
  end

  always_comb begin
    if (rd_idx_i < regs_pkg::N_SCRATCH)
      rd_data_o = scratch_q[rd_idx_i[SEL_W-1:0]];
    else if (rd_idx_i == regs_pkg::IDX_WRCNT)
      rd_data_o = wr_cnt_i;
    else if (rd_idx_i == regs_pkg::IDX_RDCNT)
      rd_data_o = rd_cnt_i;
    else
      rd_data_o = '0;
  end

endmodule

/* hw/axil_txn_counter.sv */
// Wrapping counters of completed OKAY writes and reads.
`timescale 1ns/1ps

module axil_txn_counter (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic                           wr_done_i,
  input  logic                           rd_done_i,
  output logic [axil_pkg::DATA_W-1:0]    wr_cnt_o,
  output logic [axil_pkg::DATA_W-1:0]    rd_cnt_o
);

  logic [axil_pkg::DATA_W-1:0] wr_cnt_q, rd_cnt_q;

  // Done pulses arrive at the response handshake, after the data left
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_cnt_q <= '0;
      rd_cnt_q <= '0;
    end else begin
      if (wr_done_i) wr_cnt_q <= wr_cnt_q + 1'b1;
      if (rd_done_i) rd_cnt_q <= rd_cnt_q + 1'b1;
    end
  end

  assign wr_cnt_o = wr_cnt_q;
  assign rd_cnt_o = rd_cnt_q;

endmodule

/* hw/axil_reg_subsys.sv */
// AXI-Lite register block behind NUM_CUTS pipeline stages.
// The testbench drives the slave-side channels.
`timescale 1ns/1ps

module axil_reg_subsys #(
  parameter int unsigned NUM_CUTS = 2
) (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic                           awvalid_i,
  output logic                           awready_o,
  input  logic [axil_pkg::ADDR_W-1:0]    awaddr_i,
  input  logic                           wvalid_i,
  output logic                           wready_o,
  input  logic [axil_pkg::DATA_W-1:0]    wdata_i,
  input  logic [axil_pkg::STRB_W-1:0]    wstrb_i,
  output logic                           bvalid_o,
  input  logic                           bready_i,
  output logic [axil_pkg::RESP_W-1:0]    bresp_o,
  input  logic                           arvalid_i,
  output logic                           arready_o,
  input  logic [axil_pkg::ADDR_W-1:0]    araddr_i,
  output logic                           rvalid_o,
  input  logic                           rready_i,
  output logic [axil_pkg::DATA_W-1:0]    rdata_o,
  output logic [axil_pkg::RESP_W-1:0]    rresp_o
);

  // Far end of the cut chain
  logic                           awvalid, awready, wvalid, wready, bvalid, bready;
  logic                           arvalid, arready, rvalid, rready;
  logic [axil_pkg::ADDR_W-1:0]    awaddr, araddr;
  logic [axil_pkg::DATA_W-1:0]    wdata, rdata;
  logic [axil_pkg::STRB_W-1:0]    wstrb;
  logic [axil_pkg::RESP_W-1:0]    bresp, rresp;

  // Register slave side
  logic                           wr_en, wr_done, rd_done;
  logic [regs_pkg::IDX_W-1:0]     wr_idx, rd_idx;
  logic [axil_pkg::DATA_W-1:0]    wr_data, rd_data, wr_cnt, rd_cnt;
  logic [axil_pkg::STRB_W-1:0]    wr_strb;

  axil_multicut #(.NoCuts(NUM_CUTS)) i_multicut (
    .clk_i, .rst_n_i,
    .slv_awvalid_i(awvalid_i), .slv_awready_o(awready_o), .slv_awaddr_i(awaddr_i),
    .slv_wvalid_i(wvalid_i), .slv_wready_o(wready_o),
    .slv_wdata_i(wdata_i), .slv_wstrb_i(wstrb_i),
    .slv_bvalid_o(bvalid_o), .slv_bready_i(bready_i), .slv_bresp_o(bresp_o),
    .slv_arvalid_i(arvalid_i), .slv_arready_o(arready_o), .slv_araddr_i(araddr_i),
    .slv_rvalid_o(rvalid_o), .slv_rready_i(rready_i),
    .slv_rdata_o(rdata_o), .slv_rresp_o(rresp_o),
    .mst_awvalid_o(awvalid), .mst_awready_i(awready), .mst_awaddr_o(awaddr),
    .mst_wvalid_o(wvalid), .mst_wready_i(wready), .mst_wdata_o(wdata), .mst_wstrb_o(wstrb),
    .mst_bvalid_i(bvalid), .mst_bready_o(bready), .mst_bresp_i(bresp),
    .mst_arvalid_o(arvalid), .mst_arready_i(arready), .mst_araddr_o(araddr),
    .mst_rvalid_i(rvalid), .mst_rready_o(rready), .mst_rdata_i(rdata), .mst_rresp_i(rresp)
  );

  axil_reg_ctrl i_ctrl (
    .clk_i, .rst_n_i,
    .awvalid_i(awvalid), .awready_o(awready), .awaddr_i(awaddr),
    .wvalid_i(wvalid), .wready_o(wready), .wdata_i(wdata), .wstrb_i(wstrb),
    .bvalid_o(bvalid), .bready_i(bready), .bresp_o(bresp),
    .arvalid_i(arvalid), .arready_o(arready), .araddr_i(araddr),
    .rvalid_o(rvalid), .rready_i(rready), .rdata_o(rdata), .rresp_o(rresp),
    .wr_en_o(wr_en), .wr_idx_o(wr_idx), .wr_data_o(wr_data), .wr_strb_o(wr_strb),
    .rd_idx_o(rd_idx), .rd_data_i(rd_data),
    .wr_done_o(wr_done), .rd_done_o(rd_done)
  );

  axil_reg_file i_reg_file (
    .clk_i, .rst_n_i,
    .wr_en_i(wr_en), .wr_idx_i(wr_idx), .wr_data_i(wr_data), .wr_strb_i(wr_strb),
    .rd_idx_i(rd_idx), .rd_data_o(rd_data),
    .wr_cnt_i(wr_cnt), .rd_cnt_i(rd_cnt)
  );

  axil_txn_counter i_txn_counter (
    .clk_i, .rst_n_i,
    .wr_done_i(wr_done), .rd_done_i(rd_done),
    .wr_cnt_o(wr_cnt), .rd_cnt_o(rd_cnt)
  );

endmodule

/* test/tb_axil_reg_subsys.sv */
// Testbench for the AXI-Lite register block behind two cut stages.
// Drives AW/W/AR on the falling edge, toggles bready/rready at random and
// checks every B and R beat against an in-order reference model.
`timescale 1ns/1ps

module tb_axil_reg_subsys;

  // Transactions per test section size the watchdog
  localparam int N_RESET = 6;
  localparam int N_FULL  = 8;
  localparam int N_STRB  = 12;
  localparam int N_ERR   = 12;
  localparam int N_CNT   = 2;
  localparam int N_BURST = 32;
  localparam int N_TXN   = N_RESET + N_FULL + N_STRB + N_ERR + N_CNT + N_BURST;
  localparam int WATCHDOG_CYCLES = N_TXN * 200 + 200;

  logic        clk, rst_n;
  logic        awvalid, awready, wvalid, wready, bvalid, bready;
  logic        arvalid, arready, rvalid, rready;
  logic [31:0] awaddr, araddr, wdata, rdata;
  logic [3:0]  wstrb;
  logic [1:0]  bresp, rresp;

  // Reference model state and expected responses in issue order
  logic [31:0] model_scratch [4];
  logic [31:0] model_wr_cnt, model_rd_cnt;
  logic [1:0]  exp_b_q[$];
  logic [31:0] exp_rdata_q[$];
  logic [1:0]  exp_rresp_q[$];

  // Response hold tracking between rising edges
  logic        b_wait, r_wait;
  logic [1:0]  b_hold, rresp_hold;
  logic [31:0] rdata_hold;

  axil_reg_subsys #(.NUM_CUTS(2)) uut (
    .clk_i(clk), .rst_n_i(rst_n),
    .awvalid_i(awvalid), .awready_o(awready), .awaddr_i(awaddr),
    .wvalid_i(wvalid), .wready_o(wready), .wdata_i(wdata), .wstrb_i(wstrb),
    .bvalid_o(bvalid), .bready_i(bready), .bresp_o(bresp),
    .arvalid_i(arvalid), .arready_o(arready), .araddr_i(araddr),
    .rvalid_o(rvalid), .rready_i(rready), .rdata_o(rdata), .rresp_o(rresp)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Checks failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic mismatch(input string name, input logic [31:0] exp, input logic [31:0] act);
    stop_run($sformatf("MISMATCH at %0t ns: %s expected 0x%h actual 0x%h",
                       $time, name, exp, act));
  endtask

  function automatic logic [31:0] addr_of(input int idx);
    return {27'd0, idx[2:0], 2'b00};
  endfunction

  // Writes land only in scratch words 0..3 with a zero upper field
  function automatic logic [1:0] model_write(input logic [31:0] addr, input logic [31:0] data,
                                             input logic [3:0] strb);
    if (addr[31:5] != 27'd0 || addr[4:2] > 3'd3)
      return 2'b10;
    for (int b = 0; b < 4; b++) begin
      if (strb[b])
        model_scratch[addr[3:2]][b*8 +: 8] = data[b*8 +: 8];
    end
    model_wr_cnt = model_wr_cnt + 32'd1;
    return 2'b00;
  endfunction

  // A counter read returns the count before itself
  function automatic void model_read(input logic [31:0] addr, output logic [31:0] data,
                                     output logic [1:0] resp);
    data = 32'd0;
    resp = 2'b10;
    if (addr[31:5] == 27'd0 && addr[4:2] <= 3'd5) begin
      resp = 2'b00;
      if (addr[4:2] <= 3'd3)
        data = model_scratch[addr[3:2]];
      else if (addr[4:2] == 3'd4)
        data = model_wr_cnt;
      else
        data = model_rd_cnt;
      model_rd_cnt = model_rd_cnt + 32'd1;
    end
  endfunction

  // AW and W each start after their own random gap
  task automatic send_write(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb);
    int unsigned aw_gap;
    int unsigned w_gap;
    int unsigned cyc;
    bit          aw_done;
    bit          w_done;
    aw_gap  = $urandom_range(0, 2);
    w_gap   = $urandom_range(0, 2);
    cyc     = 0;
    aw_done = 1'b0;
    w_done  = 1'b0;
    exp_b_q.push_back(model_write(addr, data, strb));
    while (!(aw_done && w_done)) begin
      if (!aw_done && cyc == aw_gap) begin
        awvalid = 1'b1;
        awaddr  = addr;
      end
      if (!w_done && cyc == w_gap) begin
        wvalid = 1'b1;
        wdata  = data;
        wstrb  = strb;
      end
      @(posedge clk);
      if (awvalid && awready)
        aw_done = 1'b1;
      if (wvalid && wready)
        w_done = 1'b1;
      @(negedge clk);
      if (aw_done)
        awvalid = 1'b0;
      if (w_done)
        wvalid = 1'b0;
      cyc++;
    end
  endtask

  task automatic send_read(input logic [31:0] addr);
    logic [31:0] data;
    logic [1:0]  resp;
    model_read(addr, data, resp);
    exp_rdata_q.push_back(data);
    exp_rresp_q.push_back(resp);
    arvalid = 1'b1;
    araddr  = addr;
    @(posedge clk);
    while (!arready)
      @(posedge clk);
    @(negedge clk);
    arvalid = 1'b0;
  endtask

  task automatic drain_responses();
    while (exp_b_q.size() != 0 || exp_rdata_q.size() != 0)
      @(posedge clk);
    @(negedge clk);
  endtask

  task automatic write_reg(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    send_write(addr, data, strb);
    drain_responses();
  endtask

  task automatic read_reg(input logic [31:0] addr);
    send_read(addr);
    drain_responses();
  endtask

  task automatic toggle_ready();
    forever begin
      @(negedge clk);
      bready = ($urandom_range(0, 3) != 0);
      rready = ($urandom_range(0, 3) != 0);
    end
  endtask

  // Response checker samples on the rising edge
  always @(posedge clk) begin : check_resp
    logic [1:0]  exp_resp;
    logic [31:0] exp_data;
    if (!rst_n) begin
      b_wait = 1'b0;
      r_wait = 1'b0;
    end else begin
      if (b_wait) begin
        assert (bvalid) else stop_run("bvalid dropped before bready");
        assert (bresp == b_hold) else mismatch("bresp (held)", b_hold, bresp);
      end
      if (r_wait) begin
        assert (rvalid) else stop_run("rvalid dropped before rready");
        assert (rdata == rdata_hold) else mismatch("rdata (held)", rdata_hold, rdata);
        assert (rresp == rresp_hold) else mismatch("rresp (held)", rresp_hold, rresp);
      end
      if (bvalid && bready) begin
        assert (exp_b_q.size() != 0) else stop_run("B response with no write outstanding");
        exp_resp = exp_b_q.pop_front();
        assert (bresp == exp_resp) else mismatch("bresp", exp_resp, bresp);
      end
      if (rvalid && rready) begin
        assert (exp_rdata_q.size() != 0) else stop_run("R response with no read outstanding");
        exp_data = exp_rdata_q.pop_front();
        exp_resp = exp_rresp_q.pop_front();
        assert (rdata == exp_data) else mismatch("rdata", exp_data, rdata);
        assert (rresp == exp_resp) else mismatch("rresp", exp_resp, rresp);
      end
      b_wait     = bvalid && !bready;
      b_hold     = bresp;
      r_wait     = rvalid && !rready;
      rdata_hold = rdata;
      rresp_hold = rresp;
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    stop_run("Timeout: responses still outstanding when the watchdog expired");
  end

  initial begin
    void'($urandom(14627));
    rst_n   = 1'b0;
    awvalid = 1'b0;
    awaddr  = '0;
    wvalid  = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    bready  = 1'b0;
    arvalid = 1'b0;
    araddr  = '0;
    rready  = 1'b0;
    model_wr_cnt = '0;
    model_rd_cnt = '0;
    for (int i = 0; i < 4; i++)
      model_scratch[i] = '0;
    fork
      toggle_ready();
    join_none
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    assert (!bvalid && !rvalid) else stop_run("Response valid high after reset");

    // Read counter goes first so it still reads zero
    for (int i = 5; i >= 0; i--)
      read_reg(addr_of(i));

    for (int i = 0; i < 4; i++)
      write_reg(addr_of(i), $urandom, 4'hf);
    for (int i = 0; i < 4; i++)
      read_reg(addr_of(i));

    for (int i = 0; i < 8; i++)
      write_reg(addr_of(i % 4), $urandom, 4'($urandom_range(0, 15)));
    for (int i = 0; i < 4; i++)
      read_reg(addr_of(i));

    // Read-only and unmapped addresses
    write_reg(addr_of(4), $urandom, 4'hf);
    write_reg(addr_of(5), $urandom, 4'hf);
    write_reg(32'h0001_0000 | addr_of(1), $urandom, 4'hf);
    read_reg(32'h0001_0000 | addr_of(0));
    read_reg(addr_of(6));
    read_reg(addr_of(7));
    for (int i = 0; i < 4; i++)
      read_reg(addr_of(i));
    read_reg(addr_of(4));
    read_reg(addr_of(5));

    // Back-to-back traffic under random back-pressure, OKAY and SLVERR writes mixed
    for (int i = 0; i < 16; i++)
      send_write(addr_of($urandom_range(0, 5)), $urandom, 4'($urandom_range(0, 15)));
    drain_responses();
    for (int i = 0; i < 16; i++)
      send_read(addr_of($urandom_range(0, 3)));
    drain_responses();
    read_reg(addr_of(4));
    read_reg(addr_of(5));

    $display("All checks passed");
    $finish;
  end

endmodule

/* list.f */
common/axil_pkg.sv
common/regs_pkg.sv
axil_cut/axil_spill_reg.sv
axil_cut/axil_cut.sv
axil_cut/axil_multicut.sv
hw/axil_reg_ctrl.sv
hw/axil_reg_file.sv
hw/axil_txn_counter.sv
hw/axil_reg_subsys.sv
test/tb_axil_reg_subsys.sv

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it.
# The exit status is nonzero if the build fails or the simulation fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_axil_reg_subsys \
  -f list.f \
  --Mdir obj_dir -o sim_tb
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/sim_tb
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi

exit 0
